/* bus_arbiter.sv */
// Two-master Wishbone arbiter
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import mem_pkg::*; (
  input  wire logic  clock,
  input  wire logic  reset,
  // Fetch master, read only
  input  wire logic  fetch_cyc,
  input  wire logic  fetch_stb,
  input  word_addr_t fetch_adr,
  output word_t      fetch_dat_r,
  output logic       fetch_ack,
  // Data master
  input  wire logic  data_cyc,
  input  wire logic  data_stb,
  input  wire logic  data_we,
  input  word_addr_t data_adr,
  input  word_t      data_dat_w,
  output word_t      data_dat_r,
  output logic       data_ack,
  // Memory slave
  output logic       mem_cyc,
  output logic       mem_stb,
  output logic       mem_we,
  output word_addr_t mem_adr,
  output word_t      mem_dat_w,
  input  word_t      mem_dat_r,
  input  wire logic  mem_ack
);

  owner_t owner;

  // Grant only from no owner, data wins a tie, release on ack
  always_ff @(posedge clock) begin
    if (reset) begin
      owner <= owner_none;
    end else if (owner == owner_none) begin
      if (data_cyc && data_stb) begin
        owner <= owner_data;
      end else if (fetch_cyc && fetch_stb) begin
        owner <= owner_fetch;
      end
    end else if (mem_ack) begin
      owner <= owner_none;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request mux toward memory
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mem_cyc   = 1'b0;
    mem_stb   = 1'b0;
    mem_we    = 1'b0;
    mem_adr   = data_adr;
    mem_dat_w = data_dat_w;
    case (owner)
      owner_data: begin
        mem_cyc = data_cyc;
        mem_stb = data_stb;
        mem_we  = data_we;
      end
      owner_fetch: begin
        // Fetch never writes
        mem_cyc = fetch_cyc;
        mem_stb = fetch_stb;
        mem_adr = fetch_adr;
      end
      default: ;
    endcase
  end

  // Responses go to the owner only
  assign fetch_ack   = (owner == owner_fetch) && mem_ack;
  assign data_ack    = (owner == owner_data) && mem_ack;
  assign fetch_dat_r = (owner == owner_fetch) ? mem_dat_r : '0;
  assign data_dat_r  = (owner == owner_data) ? mem_dat_r : '0;

  // No stray ack from the slave
  assert property (@(posedge clock) disable iff (reset)
    mem_ack |-> (owner != owner_none));

  // Owning master keeps its cycle up for the whole grant
  assert property (@(posedge clock) disable iff (reset)
    (owner == owner_data) |-> (data_cyc && data_stb));

  assert property (@(posedge clock) disable iff (reset)
    (owner == owner_fetch) |-> (fetch_cyc && fetch_stb));

endmodule

`default_nettype wire

/* data_port.sv */
// Load/store bus port
`timescale 1ns/1ps
`default_nettype none

module data_port import mem_pkg::*; (
  input  wire logic  clock,
  input  wire logic  reset,
  // Request side
  input  wire logic  data_req,
  input  wire logic  data_we,
  input  word_addr_t data_addr,
  input  word_t      data_wdata,
  output logic       data_busy,
  output logic       data_done,
  output word_t      data_rdata,
  // Wishbone master
  output logic       data_cyc,
  output logic       data_stb,
  output logic       data_bus_we,
  output word_addr_t data_adr,
  output word_t      data_dat_w,
  input  word_t      data_dat_r,
  input  wire logic  data_ack
);

  port_state_t state;

  // Registered request
  logic       req_we;
  word_addr_t req_addr;
  word_t      req_wdata;

  assign data_busy   = (state == port_bus_wait);
  assign data_cyc    = (state == port_bus_wait);
  assign data_stb    = (state == port_bus_wait);
  assign data_bus_we = req_we;
  assign data_adr    = req_addr;
  assign data_dat_w  = req_wdata;

  // One bus cycle per request, done the cycle after ack
  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= port_idle;
      data_done <= 1'b0;
    end else begin
      data_done <= 1'b0;
      if (state == port_idle && data_req) begin
        state <= port_bus_wait;
      end else if (state == port_bus_wait && data_ack) begin
        state     <= port_idle;
        data_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == port_idle && data_req) begin
      req_we    <= data_we;
      req_addr  <= data_addr;
      req_wdata <= data_wdata;
    end
    // Load data captured on the ack edge
    if (state == port_bus_wait && data_ack) begin
      data_rdata <= data_dat_r;
    end
  end

  // Arbiter routes ack only to an active master
  assert property (@(posedge clock) disable iff (reset)
    data_ack |-> (state == port_bus_wait));

endmodule

`default_nettype wire

/* icache.sv */
// Direct-mapped instruction cache
`timescale 1ns/1ps
`default_nettype none

module icache import mem_pkg::*; #(
  parameter int CACHE_LINES = CACHE_LINES_DEFAULT
) (
  input  wire logic  clock,
  input  wire logic  reset,
  // Fetch side
  input  wire logic  fetch_req,
  input  word_addr_t fetch_addr,
  output logic       fetch_ready,
  output logic       fetch_valid,
  output word_t      fetch_inst,
  // Wishbone master, read only
  output logic       fetch_cyc,
  output logic       fetch_stb,
  output word_addr_t fetch_adr,
  input  word_t      fetch_dat_r,
  input  wire logic  fetch_ack
);

  // Index from the low address bits, tag from the rest
  localparam int INDEX_W = $clog2(CACHE_LINES);
  localparam int TAG_W   = ADDR_BITS - INDEX_W;

  typedef logic [INDEX_W-1:0] line_index_t;
  typedef logic [TAG_W-1:0]   line_tag_t;

  // Cache arrays
  line_tag_t              tag_array  [CACHE_LINES];
  word_t                  data_array [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_array;

  icache_state_t state;
  word_addr_t    miss_addr;
  word_t         refill_word;

  // Lookup on the incoming address
  line_index_t req_index;
  line_tag_t   req_tag;
  logic        hit;
  logic        accept;

  // Miss address split for the refill write
  line_index_t miss_index;
  line_tag_t   miss_tag;

  assign req_index  = fetch_addr[INDEX_W-1:0];
  assign req_tag    = fetch_addr[ADDR_BITS-1:INDEX_W];
  assign hit        = valid_array[req_index] && (tag_array[req_index] == req_tag);
  assign miss_index = miss_addr[INDEX_W-1:0];
  assign miss_tag   = miss_addr[ADDR_BITS-1:INDEX_W];

  assign fetch_ready = (state == ic_idle);
  assign accept      = fetch_req && fetch_ready;

  // Bus cycle runs only while reading the missed word
  assign fetch_cyc = (state == ic_bus_read);
  assign fetch_stb = (state == ic_bus_read);
  assign fetch_adr = miss_addr;

  //////////////////////////////////////////////////////////////////////
  // Miss FSM and control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= ic_idle;
      fetch_valid <= 1'b0;
      valid_array <= '0;
    end else begin
      fetch_valid <= 1'b0;
      case (state)
        ic_idle: begin
          // Hit answers next cycle, miss goes to the bus
          if (accept && hit) begin
            fetch_valid <= 1'b1;
          end else if (accept) begin
            state <= ic_bus_read;
          end
        end
        ic_bus_read: begin
          if (fetch_ack) begin
            state <= ic_refill;
          end
        end
        ic_refill: begin
          valid_array[miss_index] <= 1'b1;
          fetch_valid             <= 1'b1;
          state                   <= ic_idle;
        end
        default: state <= ic_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Arrays and payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (state == ic_idle && accept) begin
      miss_addr  <= fetch_addr;
      fetch_inst <= data_array[req_index];
    end
    // Word from memory, held for the refill step
    if (state == ic_bus_read && fetch_ack) begin
      refill_word <= fetch_dat_r;
    end
    if (state == ic_refill) begin
      tag_array[miss_index]  <= miss_tag;
      data_array[miss_index] <= refill_word;
      fetch_inst             <= refill_word;
    end
  end

  // Line count limits
  initial begin
    assert (CACHE_LINES >= 2 && (CACHE_LINES & (CACHE_LINES - 1)) == 0)
      else $fatal(1, "icache: CACHE_LINES must be a power of two, at least 2");
  end

  // Ack only answers an active bus read
  assert property (@(posedge clock) disable iff (reset)
    fetch_ack |-> fetch_stb);

endmodule

`default_nettype wire

/* main_memory.sv */
// Wishbone word memory with wait states
`timescale 1ns/1ps
`default_nettype none

module main_memory import mem_pkg::*; #(
  parameter int MEM_WORDS   = MEM_WORDS_DEFAULT,
  parameter int WAIT_STATES = WAIT_STATES_DEFAULT
) (
  input  wire logic  clock,
  input  wire logic  reset,
  input  wire logic  mem_cyc,
  input  wire logic  mem_stb,
  input  wire logic  mem_we,
  input  word_addr_t mem_adr,
  input  word_t      mem_dat_w,
  output word_t      mem_dat_r,
  output logic       mem_ack
);

  localparam int MEM_ADDR_W = $clog2(MEM_WORDS);
  localparam int CNT_W      = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  // Word storage, no reset
  word_t mem_array [MEM_WORDS];

  logic [CNT_W-1:0] wait_count;
  logic             last_wait;

  assign last_wait = (wait_count == CNT_W'(WAIT_STATES));

  // Count wait states, then one ack cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      wait_count <= '0;
      mem_ack    <= 1'b0;
    end else if (mem_ack || !(mem_cyc && mem_stb)) begin
      wait_count <= '0;
      mem_ack    <= 1'b0;
    end else if (last_wait) begin
      wait_count <= '0;
      mem_ack    <= 1'b1;
    end else begin
      wait_count <= wait_count + 1'b1;
    end
  end

  // Array access on the edge that raises ack
  always_ff @(posedge clock) begin
    if (mem_cyc && mem_stb && !mem_ack && last_wait) begin
      if (mem_we) begin
        mem_array[mem_adr[MEM_ADDR_W-1:0]] <= mem_dat_w;
      end
      mem_dat_r <= mem_array[mem_adr[MEM_ADDR_W-1:0]];
    end
  end

  initial begin
    assert (MEM_WORDS >= 2 && MEM_WORDS <= (1 << ADDR_BITS) && WAIT_STATES >= 0)
      else $fatal(1, "main_memory: MEM_WORDS or WAIT_STATES out of range");
  end

  // Master still strobing while ack is up
  assert property (@(posedge clock) disable iff (reset)
    mem_ack |-> (mem_cyc && mem_stb));

  // Address inside the array
  assert property (@(posedge clock) disable iff (reset)
    (mem_cyc && mem_stb) |-> (mem_adr < MEM_WORDS));

endmodule

`default_nettype wire

/* mem_pkg.sv */
// Memory subsystem shared types
`default_nettype none

package mem_pkg;

  // Bus and address widths
  localparam int WORD_BITS = 32;
  localparam int ADDR_BITS = 16;

  // Defaults handed down by the top level
  localparam int MEM_WORDS_DEFAULT   = 1024;
  localparam int CACHE_LINES_DEFAULT = 16;
  localparam int WAIT_STATES_DEFAULT = 2;

  // One instruction or data word
  typedef logic [WORD_BITS-1:0] word_t;

  // Word address, 64 K words
  typedef logic [ADDR_BITS-1:0] word_addr_t;

  // Instruction cache miss FSM
  typedef enum logic [1:0] {ic_idle, ic_bus_read, ic_refill} icache_state_t;

  // Load/store unit FSM
  typedef enum logic {port_idle, port_bus_wait} port_state_t;

  // Current bus owner in the arbiter
  typedef enum logic [1:0] {owner_none, owner_fetch, owner_data} owner_t;

endpackage

`default_nettype wire

/* mem_subsystem.sv */
// Memory subsystem top level
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem import mem_pkg::*; #(
  parameter int CACHE_LINES = CACHE_LINES_DEFAULT,
  parameter int MEM_WORDS   = MEM_WORDS_DEFAULT,
  parameter int WAIT_STATES = WAIT_STATES_DEFAULT
) (
  input  wire logic  clock,
  input  wire logic  reset,
  // Fetch port
  input  wire logic  fetch_req,
  input  word_addr_t fetch_addr,
  output logic       fetch_ready,
  output logic       fetch_valid,
  output word_t      fetch_inst,
  // Data port
  input  wire logic  data_req,
  input  wire logic  data_we,
  input  word_addr_t data_addr,
  input  word_t      data_wdata,
  output logic       data_busy,
  output logic       data_done,
  output word_t      data_rdata
);

  ////////////////////////////////////////////////////////////////////
  // Bus wires
  ////////////////////////////////////////////////////////////////////

  // Cache master
  logic       fetch_cyc;
  logic       fetch_stb;
  word_addr_t fetch_adr;
  word_t      fetch_dat_r;
  logic       fetch_ack;

  // Data master
  logic       data_cyc;
  logic       data_stb;
  logic       data_bus_we;
  word_addr_t data_adr;
  word_t      data_dat_w;
  word_t      data_dat_r;
  logic       data_ack;

  // Shared memory side
  logic       mem_cyc;
  logic       mem_stb;
  logic       mem_we;
  word_addr_t mem_adr;
  word_t      mem_dat_w;
  word_t      mem_dat_r;
  logic       mem_ack;

  icache #(
    .CACHE_LINES (CACHE_LINES)
  ) icache_0 (
    .clock       (clock),
    .reset       (reset),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_valid (fetch_valid),
    .fetch_inst  (fetch_inst),
    .fetch_cyc   (fetch_cyc),
    .fetch_stb   (fetch_stb),
    .fetch_adr   (fetch_adr),
    .fetch_dat_r (fetch_dat_r),
    .fetch_ack   (fetch_ack)
  );

  data_port data_port_0 (
    .clock       (clock),
    .reset       (reset),
    .data_req    (data_req),
    .data_we     (data_we),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_busy   (data_busy),
    .data_done   (data_done),
    .data_rdata  (data_rdata),
    .data_cyc    (data_cyc),
    .data_stb    (data_stb),
    .data_bus_we (data_bus_we),
    .data_adr    (data_adr),
    .data_dat_w  (data_dat_w),
    .data_dat_r  (data_dat_r),
    .data_ack    (data_ack)
  );

  // Data port has priority over fetch
  bus_arbiter arbiter_0 (
    .clock       (clock),
    .reset       (reset),
    .fetch_cyc   (fetch_cyc),
    .fetch_stb   (fetch_stb),
    .fetch_adr   (fetch_adr),
    .fetch_dat_r (fetch_dat_r),
    .fetch_ack   (fetch_ack),
    .data_cyc    (data_cyc),
    .data_stb    (data_stb),
    .data_we     (data_bus_we),
    .data_adr    (data_adr),
    .data_dat_w  (data_dat_w),
    .data_dat_r  (data_dat_r),
    .data_ack    (data_ack),
    .mem_cyc     (mem_cyc),
    .mem_stb     (mem_stb),
    .mem_we      (mem_we),
    .mem_adr     (mem_adr),
    .mem_dat_w   (mem_dat_w),
    .mem_dat_r   (mem_dat_r),
    .mem_ack     (mem_ack)
  );

  main_memory #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) memory_0 (
    .clock     (clock),
    .reset     (reset),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .mem_dat_r (mem_dat_r),
    .mem_ack   (mem_ack)
  );

endmodule

`default_nettype wire

/* mem_subsystem_tb.sv */
// Memory subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb import mem_pkg::*; ();

  localparam int LINES      = CACHE_LINES_DEFAULT;
  localparam int WORDS      = MEM_WORDS_DEFAULT;
  localparam int WAIT_LIMIT = 100;

  logic       clock;
  logic       reset;
  logic       fetch_req;
  word_addr_t fetch_addr;
  logic       fetch_ready;
  logic       fetch_valid;
  word_t      fetch_inst;
  logic       data_req;
  logic       data_we;
  word_addr_t data_addr;
  word_t      data_wdata;
  logic       data_busy;
  logic       data_done;
  word_t      data_rdata;

  // Reference memory, only written words are ever read back
  word_t ref_mem     [WORDS];
  bit    ref_written [WORDS];

  // Reference copy of the cache lines
  word_t ref_line  [LINES];
  int    ref_tag   [LINES];
  bit    ref_valid [LINES];

  int error_count;
  int test_errors;
  int test_count;
  bit aborted;

  tb_clock #(.PERIOD(20)) clock_gen (.clock(clock));

  mem_subsystem uut (
    .clock       (clock),
    .reset       (reset),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_valid (fetch_valid),
    .fetch_inst  (fetch_inst),
    .data_req    (data_req),
    .data_we     (data_we),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_busy   (data_busy),
    .data_done   (data_done),
    .data_rdata  (data_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Checking and reporting
  //////////////////////////////////////////////////////////////////////

  task automatic compare_word(input word_t got, input word_t want, input string what);
    if (got !== want) begin
      $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, want);
      error_count++;
      test_errors++;
    end
  endtask

  // Stuck run, the remaining operations are skipped
  task automatic abort_run(input string why);
    $display("Run stopped: %s", why);
    aborted = 1'b1;
  endtask

  task automatic close_test(input string name);
    string status;
    status = aborted ? "aborted" : ((test_errors == 0) ? "ok" : "mismatch");
    $display("test %0d %s: %s", test_count, name, status);
    test_count++;
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic model_store(input word_addr_t addr, input word_t data);
    // Stores update memory only, cache lines stay as they are
    ref_mem[addr]     = data;
    ref_written[addr] = 1'b1;
  endtask

  task automatic model_fetch(input word_addr_t addr, output word_t want, output bit hit);
    int idx;
    int tag;
    idx = int'(addr) % LINES;
    tag = int'(addr) / LINES;
    hit = ref_valid[idx] && (ref_tag[idx] == tag);
    // Miss refills the line from current memory
    if (!hit) begin
      ref_line[idx]  = ref_mem[addr];
      ref_tag[idx]   = tag;
      ref_valid[idx] = 1'b1;
    end
    want = ref_line[idx];
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus-side drivers, all on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic wait_fetch_ready();
    int n;
    n = 0;
    while (!fetch_ready) begin
      if (n >= WAIT_LIMIT) begin
        abort_run("fetch_ready stayed low too long");
        return;
      end
      @(negedge clock);
      n++;
    end
  endtask

  task automatic wait_data_idle();
    int n;
    n = 0;
    while (data_busy) begin
      if (n >= WAIT_LIMIT) begin
        abort_run("data_busy stayed high too long");
        return;
      end
      @(negedge clock);
      n++;
    end
  endtask

  task automatic run_data_op(input bit we, input word_addr_t addr, input word_t wdata,
                             output word_t rdata);
    int n;
    rdata = '0;
    wait_data_idle();
    if (aborted) return;
    data_req   = 1'b1;
    data_we    = we;
    data_addr  = addr;
    data_wdata = wdata;
    // Taken on the rising edge in between
    @(negedge clock);
    data_req = 1'b0;
    n = 0;
    while (!data_done) begin
      if (n >= WAIT_LIMIT) begin
        abort_run("data_done never came");
        return;
      end
      @(negedge clock);
      n++;
    end
    rdata = data_rdata;
  endtask

  task automatic store_word(input word_addr_t addr, input word_t data);
    word_t unused;
    model_store(addr, data);
    run_data_op(1'b1, addr, data, unused);
  endtask

  task automatic load_and_check(input word_addr_t addr, output word_t got);
    run_data_op(1'b0, addr, '0, got);
    if (aborted) return;
    compare_word(got, ref_mem[addr], $sformatf("load %h vs reference memory", addr));
  endtask

  task automatic fetch_and_check(input word_addr_t addr, output word_t got);
    word_t want;
    bit    hit;
    int    latency;
    got = '0;
    model_fetch(addr, want, hit);
    wait_fetch_ready();
    if (aborted) return;
    fetch_req  = 1'b1;
    fetch_addr = addr;
    @(negedge clock);
    fetch_req = 1'b0;
    // Cycles counted from the accepting edge
    latency = 1;
    while (!fetch_valid) begin
      if (latency >= WAIT_LIMIT) begin
        abort_run("fetch_valid never came");
        return;
      end
      @(negedge clock);
      latency++;
    end
    got = fetch_inst;
    compare_word(got, want, $sformatf("fetch %h vs reference cache", addr));
    if (hit) begin
      compare_word(word_t'(latency), 1, $sformatf("hit latency at %h", addr));
    end else begin
      compare_word(word_t'(latency > 1), 1, $sformatf("miss latency at %h", addr));
    end
  endtask

  // Fetch and store issued on the same edge
  task automatic run_pair(input word_addr_t faddr, input word_addr_t daddr);
    word_t store_data;
    word_t want;
    word_t got;
    bit    hit;
    bit    fetch_seen;
    bit    store_seen;
    int    n;
    store_data = {~daddr, daddr};
    wait_fetch_ready();
    if (aborted) return;
    wait_data_idle();
    if (aborted) return;
    // Data master wins the tie, so its write lands before a missed fetch reads
    model_store(daddr, store_data);
    model_fetch(faddr, want, hit);
    fetch_req  = 1'b1;
    fetch_addr = faddr;
    data_req   = 1'b1;
    data_we    = 1'b1;
    data_addr  = daddr;
    data_wdata = store_data;
    @(negedge clock);
    fetch_req  = 1'b0;
    data_req   = 1'b0;
    fetch_seen = 1'b0;
    store_seen = 1'b0;
    got        = '0;
    n          = 0;
    while (1) begin
      if (fetch_valid) begin
        fetch_seen = 1'b1;
        got        = fetch_inst;
      end
      if (data_done) store_seen = 1'b1;
      if (fetch_seen && store_seen) break;
      if (n >= WAIT_LIMIT) begin
        abort_run("paired fetch and store did not both finish");
        return;
      end
      @(negedge clock);
      n++;
    end
    compare_word(got, want, $sformatf("paired fetch %h", faddr));
  endtask

  // Random stores, loads and fetches over the first 64 words
  task automatic random_mix(input int count);
    word_addr_t addr;
    int         kind;
    word_t      got;
    repeat (count) begin
      if (aborted) return;
      addr = word_addr_t'($urandom % 64);
      kind = int'($urandom % 3);
      // Never read a word that was not written
      if (kind == 0 || !ref_written[addr]) begin
        store_word(addr, $urandom);
      end else if (kind == 1) begin
        load_and_check(addr, got);
      end else begin
        fetch_and_check(addr, got);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int         fd;
    logic [7:0] op;
    word_t      a;
    word_t      b;
    word_t      got;
    void'($urandom(32'hd7dc182a));
    reset       = 1'b1;
    fetch_req   = 1'b0;
    fetch_addr  = '0;
    data_req    = 1'b0;
    data_we     = 1'b0;
    data_addr   = '0;
    data_wdata  = '0;
    error_count = 0;
    test_errors = 0;
    test_count  = 0;
    aborted     = 1'b0;
    foreach (ref_written[i]) ref_written[i] = 1'b0;
    foreach (ref_valid[i]) ref_valid[i] = 1'b0;

    repeat (5) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    // Idle outputs after reset
    compare_word(word_t'(fetch_ready), 1, "fetch_ready after reset");
    compare_word(word_t'(data_busy), 0, "data_busy after reset");
    compare_word(word_t'(fetch_valid), 0, "fetch_valid after reset");
    compare_word(word_t'(data_done), 0, "data_done after reset");
    close_test("reset state");

    fd = $fopen("mem_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open mem_testdata.txt");
    end else begin
      // Each line is an op letter and two hex fields
      while (!aborted && $fscanf(fd, "%s %h %h", op, a, b) == 3) begin
        case (op)
          "W": store_word(word_addr_t'(a), b);
          "R": begin
            load_and_check(word_addr_t'(a), got);
            if (!aborted) compare_word(got, b, $sformatf("load %h vs data file", a));
          end
          "F": begin
            fetch_and_check(word_addr_t'(a), got);
            if (!aborted) compare_word(got, b, $sformatf("fetch %h vs data file", a));
          end
          "P": run_pair(word_addr_t'(a), word_addr_t'(b));
          "X": random_mix(int'(a));
          default: abort_run("unknown operation in mem_testdata.txt");
        endcase
        close_test($sformatf("%s %h %h", op, a, b));
      end
      $fclose(fd);
    end

    $display("tests run %0d, errors %0d", test_count, error_count);
    if (error_count == 0 && !aborted) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mem_testdata.txt */
W 0010 1111aaaa
W 0011 2222bbbb
W 0012 3333cccc
R 0010 1111aaaa
R 0011 2222bbbb
R 0012 3333cccc
F 0010 1111aaaa
F 0010 1111aaaa
W 0010 4444dddd
F 0010 1111aaaa
R 0010 4444dddd
W 0020 5555eeee
F 0020 5555eeee
F 0010 4444dddd
P 0011 0030
R 0030 ffcf0030
F 0011 2222bbbb
F 0030 ffcf0030
P 0030 0031
X 0040 00000000

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_subsystem_tb \
  -f sim.f \
  -o mem_sim

./obj_dir/mem_sim | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* sim.f */
mem_pkg.sv
icache.sv
data_port.sv
bus_arbiter.sv
main_memory.sv
mem_subsystem.sv
tb_clock.sv
mem_subsystem_tb.sv

/* tb_clock.sv */
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clock
);

  // Low at time zero, first rising edge after half a period
  initial clock = 1'b0;

  always #(PERIOD / 2) clock = ~clock;

endmodule

`default_nettype wire
